// File: instr_fetch.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_array.sv
rtl/apb_line_reader.sv
rtl/icache_ctrl.sv
rtl/instr_fetch.sv
tests/apb_mem_model.sv
tests/tb_instr_fetch.sv

// File: rtl/apb_line_reader.sv
`timescale 1ns/1ns

`include "icache_consts.svh"

module apb_line_reader
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst,

    // Refill request from the controller.
    input  logic                      i_start,
    input  logic [`ICACHE_ADDR_W-1:0] i_line_addr,

    // APB master.
    output apb_req_t                  o_apb,
    input  apb_rsp_t                  i_apb,

    // Assembled line.
    output logic                      o_done,
    output cache_line_t               o_line
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_SETUP,
        RD_ACCESS
    } rd_state_t;

    rd_state_t                                   state_q;
    logic [`ICACHE_WORD_OFS_W-1:0]               word_cnt_q;
    logic [`ICACHE_ADDR_W-`ICACHE_INDEX_LSB-1:0] line_base_q;
    logic                                        xfer_done;

    // Access phase ends on the edge with pready.
    assign xfer_done = (state_q == RD_ACCESS) && i_apb.pready;

    // ----------------------------------------------------------------------
    // Transfer sequencing.
    // ----------------------------------------------------------------------

    // The counter wraps to zero after word 15, so a nonzero count
    // in idle means the line is still in progress.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state_q    <= RD_IDLE;
            word_cnt_q <= '0;
            o_done     <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state_q)
                RD_IDLE: begin
                    if (i_start || (word_cnt_q != '0)) begin
                        state_q <= RD_SETUP;
                    end
                end
                RD_SETUP: begin
                    state_q <= RD_ACCESS;
                end
                RD_ACCESS: begin
                    if (xfer_done) begin
                        state_q    <= RD_IDLE;
                        word_cnt_q <= word_cnt_q + 1'b1;
                        o_done     <= (word_cnt_q == '1);
                    end
                end
                default: begin
                    state_q <= RD_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Line base and data capture.
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (i_start) begin
            line_base_q <= i_line_addr[`ICACHE_ADDR_W-1:`ICACHE_INDEX_LSB];
        end
    end

    // The word is kept as read even on pslverr.
    always_ff @(posedge clk) begin
        if (xfer_done) begin
            o_line[word_cnt_q] <= i_apb.prdata;
        end
    end

    always_comb begin
        o_apb.psel    = (state_q != RD_IDLE);
        o_apb.penable = (state_q == RD_ACCESS);
        o_apb.paddr   = {line_base_q, word_cnt_q, {`ICACHE_BYTE_OFS_W{1'b0}}};
    end

endmodule

// File: rtl/icache_array.sv
`timescale 1ns/1ns

`include "icache_consts.svh"

module icache_array
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst,

    // Lookup and refill write.
    input  logic [`ICACHE_ADDR_W-1:0] i_lookup_addr,
    input  logic                      i_write_en,
    input  cache_line_t               i_write_line,
    input  logic                      i_invalidate,

    // Lookup result.
    output logic                      o_hit,
    output logic [`ICACHE_WORD_W-1:0] o_word
);

    // ----------------------------------------------------------------------
    // Address fields.
    // ----------------------------------------------------------------------

    logic [`ICACHE_TAG_W-1:0]      addr_tag;
    logic [`ICACHE_INDEX_W-1:0]    addr_index;
    logic [`ICACHE_WORD_OFS_W-1:0] addr_word;

    assign addr_tag   = i_lookup_addr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
    assign addr_index = i_lookup_addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
    assign addr_word  = i_lookup_addr[`ICACHE_INDEX_LSB-1:`ICACHE_WORD_OFS_LSB];

    // ----------------------------------------------------------------------
    // Storage.
    // ----------------------------------------------------------------------

    logic [`ICACHE_TAG_W-1:0]  tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]  valid_q;
    logic [`ICACHE_LINE_W-1:0] sel_line;

    // Invalidate clears everything, but a refill landing in the
    // same cycle still marks its own line.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_q <= '0;
        end else begin
            if (i_invalidate) begin
                valid_q <= '0;
            end
            if (i_write_en) begin
                valid_q[addr_index] <= 1'b1;
            end
        end
    end

    // Tag and line are written together at the lookup index.
    always_ff @(posedge clk) begin
        if (i_write_en) begin
            tag_mem[addr_index]  <= addr_tag;
            line_mem[addr_index] <= i_write_line;
        end
    end

    // ----------------------------------------------------------------------
    // Lookup.
    // ----------------------------------------------------------------------

    assign sel_line = line_mem[addr_index];

    assign o_hit  = valid_q[addr_index] && (tag_mem[addr_index] == addr_tag);

    // Word select by the word offset.
    assign o_word = sel_line[addr_word*`ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

// File: rtl/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// Cache geometry.
`define ICACHE_ADDR_W           32
`define ICACHE_WORD_W           32
`define ICACHE_LINE_W           512
`define ICACHE_LINES            4
`define ICACHE_WORDS_PER_LINE   16

// Address field widths.
`define ICACHE_BYTE_OFS_W       2
`define ICACHE_WORD_OFS_W       4
`define ICACHE_INDEX_W          2
`define ICACHE_TAG_W            24

// Low bit of each address field.
`define ICACHE_WORD_OFS_LSB     `ICACHE_BYTE_OFS_W
`define ICACHE_INDEX_LSB        (`ICACHE_WORD_OFS_LSB + `ICACHE_WORD_OFS_W)
`define ICACHE_TAG_LSB          (`ICACHE_INDEX_LSB + `ICACHE_INDEX_W)

`endif

// File: rtl/icache_ctrl.sv
`timescale 1ns/1ns

`include "icache_consts.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst,

    // Fetch request and response.
    input  logic                      i_req_valid,
    input  fetch_req_t                i_req,
    output logic                      o_req_ready,
    output logic                      o_rsp_valid,
    output fetch_rsp_t                o_rsp,

    // Cache array.
    output logic [`ICACHE_ADDR_W-1:0] o_lookup_addr,
    input  logic                      i_hit,
    input  logic [`ICACHE_WORD_W-1:0] i_word,

    // Line reader.
    output logic                      o_fill_start,
    output logic [`ICACHE_ADDR_W-1:0] o_fill_addr,
    input  logic                      i_fill_done,
    output logic                      o_write_en
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL,
        ST_WRITE
    } state_t;

    state_t                    state_q;
    logic [`ICACHE_ADDR_W-1:0] addr_q;
    logic                      misaligned;
    logic                      answer;

    assign misaligned = |addr_q[`ICACHE_BYTE_OFS_W-1:0];

    // Misaligned requests answer without touching the cache.
    assign answer = misaligned || i_hit;

    // ----------------------------------------------------------------------
    // State machine.
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (i_req_valid) begin
                        state_q <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state_q <= answer ? ST_IDLE : ST_FILL;
                end
                ST_FILL: begin
                    if (i_fill_done) begin
                        state_q <= ST_WRITE;
                    end
                end
                // Back to lookup, which now hits.
                ST_WRITE: begin
                    state_q <= ST_LOOKUP;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_req_ready && i_req_valid) begin
            addr_q <= i_req.addr;
        end
    end

    // ----------------------------------------------------------------------
    // Outputs.
    // ----------------------------------------------------------------------

    assign o_req_ready   = (state_q == ST_IDLE);
    assign o_rsp_valid   = (state_q == ST_LOOKUP) && answer;
    assign o_fill_start  = (state_q == ST_LOOKUP) && !answer;
    assign o_write_en    = (state_q == ST_WRITE);
    assign o_lookup_addr = addr_q;

    // Line base has the word and byte offsets cleared.
    assign o_fill_addr = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_INDEX_LSB], {`ICACHE_INDEX_LSB{1'b0}}};

    assign o_rsp.instr      = misaligned ? '0 : i_word;
    assign o_rsp.misaligned = misaligned;

endmodule

// File: rtl/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    // ----------------------------------------------------------------------
    // Fetch port.
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
    } fetch_req_t;

    // Instruction reads as zero when the address is misaligned.
    typedef struct packed {
        logic [`ICACHE_WORD_W-1:0] instr;
        logic                      misaligned;
    } fetch_rsp_t;

    // ----------------------------------------------------------------------
    // APB read-only master and slave halves.
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic [`ICACHE_ADDR_W-1:0] paddr;
    } apb_req_t;

    typedef struct packed {
        logic                      pready;
        logic [`ICACHE_WORD_W-1:0] prdata;
        logic                      pslverr;
    } apb_rsp_t;

    // Word 0 sits in the low bits.
    typedef logic [`ICACHE_WORDS_PER_LINE-1:0][`ICACHE_WORD_W-1:0] cache_line_t;

endpackage

// File: rtl/instr_fetch.sv
`timescale 1ns/1ns

`include "icache_consts.svh"

module instr_fetch
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       arst,

    // Core side.
    input  logic       i_req_valid,
    input  fetch_req_t i_req,
    output logic       o_req_ready,
    output logic       o_rsp_valid,
    output fetch_rsp_t o_rsp,
    input  logic       i_invalidate,

    // Memory side.
    output apb_req_t   o_apb,
    input  apb_rsp_t   i_apb
);

    logic [`ICACHE_ADDR_W-1:0] lookup_addr;
    logic                      hit;
    logic [`ICACHE_WORD_W-1:0] word;
    logic                      fill_start;
    logic [`ICACHE_ADDR_W-1:0] fill_addr;
    logic                      fill_done;
    logic                      write_en;
    cache_line_t               fill_line;

    icache_ctrl u_ctrl (
        .clk           (clk),
        .arst          (arst),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .o_req_ready   (o_req_ready),
        .o_rsp_valid   (o_rsp_valid),
        .o_rsp         (o_rsp),
        .o_lookup_addr (lookup_addr),
        .i_hit         (hit),
        .i_word        (word),
        .o_fill_start  (fill_start),
        .o_fill_addr   (fill_addr),
        .i_fill_done   (fill_done),
        .o_write_en    (write_en)
    );

    // Refill line goes straight into the array.
    icache_array u_array (
        .clk           (clk),
        .arst          (arst),
        .i_lookup_addr (lookup_addr),
        .i_write_en    (write_en),
        .i_write_line  (fill_line),
        .i_invalidate  (i_invalidate),
        .o_hit         (hit),
        .o_word        (word)
    );

    apb_line_reader u_reader (
        .clk           (clk),
        .arst          (arst),
        .i_start       (fill_start),
        .i_line_addr   (fill_addr),
        .o_apb         (o_apb),
        .i_apb         (i_apb),
        .o_done        (fill_done),
        .o_line        (fill_line)
    );

endmodule

// File: tests/apb_mem_model.sv
`timescale 1ns/1ns

`include "icache_consts.svh"

module apb_mem_model
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     arst,
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb
);

    // Every word is its own address with this pattern mixed in.
    localparam logic [`ICACHE_WORD_W-1:0] DATA_MASK = 32'hA5A50000;

    int                        seed = 71544;
    int                        wait_left;
    logic                      in_setup;
    logic                      in_access;
    logic                      was_ready;
    logic [`ICACHE_ADDR_W-1:0] addr;

    // ----------------------------------------------------------------------
    // Bus sampled on the edge and answered 1 ns later.
    // ----------------------------------------------------------------------

    always @(posedge clk or posedge arst) begin
        if (arst) begin
            wait_left = 0;
            o_apb     = '0;
        end else begin
            in_setup  = i_apb.psel && !i_apb.penable;
            in_access = i_apb.psel && i_apb.penable;
            was_ready = o_apb.pready;
            addr      = i_apb.paddr;
            #1;
            if (in_access && was_ready) begin
                // Transfer completed on this edge.
                o_apb.pready  = 1'b0;
                o_apb.pslverr = 1'b0;
            end else begin
                // Access phase begins, so pick 0 to 3 wait states.
                if (in_setup) begin
                    wait_left = $random(seed) & 3;
                end else if (in_access) begin
                    wait_left = wait_left - 1;
                end
                if ((in_setup || in_access) && (wait_left == 0)) begin
                    o_apb.pready  = 1'b1;
                    o_apb.prdata  = addr ^ DATA_MASK;
                    // Slave error on every fourth word.
                    o_apb.pslverr = (addr[3:2] == 2'b11);
                end
            end
        end
    end

endmodule

// File: tests/tb_instr_fetch.sv
`timescale 1ns/1ns

`include "icache_consts.svh"

module tb_instr_fetch
    import icache_pkg::*;
();

    // Up to 200 requests, each well under 120 cycles even with slow APB.
    localparam int TIMEOUT_CYCLES = 200 * 120;
    localparam int LINE_WORDS     = `ICACHE_WORDS_PER_LINE;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic [31:0]               accept_cycle;
        logic                      fast;
    } pending_t;

    logic       clk;
    logic       arst;
    logic       req_valid;
    fetch_req_t req;
    logic       req_ready;
    logic       rsp_valid;
    fetch_rsp_t rsp;
    logic       invalidate;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;

    int                        seed = 71544;
    int                        cycle = 0;
    int                        rsp_seen = 0;
    int                        apb_count = 0;
    int                        xfer_idx = 0;
    logic [`ICACHE_ADDR_W-1:0] cur_base;
    pending_t                  pending [$];

    // Model of which tag each line holds.
    logic [`ICACHE_LINES-1:0]  res_valid;
    logic [`ICACHE_TAG_W-1:0]  res_tag [`ICACHE_LINES];

    instr_fetch DUT (
        .clk          (clk),
        .arst         (arst),
        .i_req_valid  (req_valid),
        .i_req        (req),
        .o_req_ready  (req_ready),
        .o_rsp_valid  (rsp_valid),
        .o_rsp        (rsp),
        .i_invalidate (invalidate),
        .o_apb        (apb_req),
        .i_apb        (apb_rsp)
    );

    apb_mem_model u_mem (
        .clk   (clk),
        .arst  (arst),
        .i_apb (apb_req),
        .o_apb (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run stalled for %0d cycles without finishing.", cycle);
            abort_run();
        end
    end

    // ----------------------------------------------------------------------
    // Reference model and compare tasks.
    // ----------------------------------------------------------------------

    function automatic fetch_rsp_t expected_word(logic [`ICACHE_ADDR_W-1:0] addr);
        fetch_rsp_t r;
        r.misaligned = (addr[`ICACHE_BYTE_OFS_W-1:0] != '0);
        r.instr      = r.misaligned ? '0 : (addr ^ 32'hA5A50000);
        return r;
    endfunction

    function automatic int predict_xfers(logic [`ICACHE_ADDR_W-1:0] addr);
        logic [`ICACHE_INDEX_W-1:0] idx;
        idx = addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
        if (addr[`ICACHE_BYTE_OFS_W-1:0] != '0) begin
            return 0;
        end
        if (res_valid[idx] && (res_tag[idx] == addr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB])) begin
            return 0;
        end
        return LINE_WORDS;
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_rsp(input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: o_rsp got instr=%h misaligned=%b, %s%h misaligned=%b",
                     $time, got.instr, got.misaligned, "expected instr=", exp.instr,
                     exp.misaligned);
            abort_run();
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: o_req_ready got %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_apb_count(input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t ns: APB transfer count got %0d, expected %0d",
                     $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_paddr(input logic [`ICACHE_ADDR_W-1:0] got,
                               input logic [`ICACHE_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: o_apb.paddr got %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t ns: o_rsp_valid latency got %0d, expected %0d",
                     $time, got, exp);
            abort_run();
        end
    endtask

    // ----------------------------------------------------------------------
    // Monitors.
    // ----------------------------------------------------------------------

    // Refill words come in ascending order from the line base.
    always @(posedge clk) begin
        if (!arst && apb_req.psel && apb_req.penable && apb_rsp.pready) begin
            check_paddr(apb_req.paddr, cur_base + 4 * xfer_idx);
            xfer_idx  = xfer_idx + 1;
            apb_count = apb_count + 1;
        end
    end

    always @(posedge clk) begin
        pending_t head;
        if (!arst && rsp_valid) begin
            if (pending.size() == 0) begin
                $display("A response arrived at %0t ns with no request outstanding.", $time);
                abort_run();
            end else begin
                head = pending.pop_front();
                check_rsp(rsp, expected_word(head.addr));
                // The controller stays busy until the response is out.
                check_ready(req_ready, 1'b0);
                if (head.fast) begin
                    check_latency(cycle - head.accept_cycle, 1);
                end
                rsp_seen = rsp_seen + 1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus.
    // ----------------------------------------------------------------------

    // Every fetch starts from an idle controller, so the first edge accepts.
    task automatic fetch(input logic [`ICACHE_ADDR_W-1:0] addr, input int exp_xfers);
        int       start_count;
        int       target;
        pending_t p;
        start_count = apb_count;
        target      = rsp_seen + 1;
        cur_base    = (addr >> `ICACHE_INDEX_LSB) << `ICACHE_INDEX_LSB;
        xfer_idx    = 0;
        req_valid   = 1'b1;
        req.addr    = addr;
        @(posedge clk);
        check_ready(req_ready, 1'b1);
        p.addr         = addr;
        p.accept_cycle = cycle;
        p.fast         = (exp_xfers == 0);
        pending.push_back(p);
        #1;
        req_valid = 1'b0;
        wait (rsp_seen == target);
        #1;
        check_apb_count(apb_count - start_count, exp_xfers);
        if (addr[`ICACHE_BYTE_OFS_W-1:0] == '0) begin
            res_valid[addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB]] = 1'b1;
            res_tag[addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB]] =
                addr[`ICACHE_ADDR_W-1:`ICACHE_TAG_LSB];
        end
    endtask

    task automatic pulse_invalidate();
        invalidate = 1'b1;
        @(posedge clk);
        #1;
        invalidate = 1'b0;
        res_valid  = '0;
    endtask

    initial begin
        logic [`ICACHE_ADDR_W-1:0] addr;
        arst       = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        invalidate = 1'b0;
        res_valid  = '0;
        repeat (8) @(posedge clk);
        #1;
        arst = 1'b0;
        @(posedge clk);
        #1;

        // Cold misses, one per line.
        fetch(32'h1000_0004, LINE_WORDS);
        fetch(32'h1000_0048, LINE_WORDS);
        fetch(32'h1000_0090, LINE_WORDS);
        fetch(32'h1000_00FC, LINE_WORDS);
        // Hits anywhere in resident lines.
        fetch(32'h1000_0000, 0);
        fetch(32'h1000_003C, 0);
        fetch(32'h1000_0040, 0);
        fetch(32'h1000_0080, 0);
        fetch(32'h1000_00C0, 0);
        fetch(32'h1000_00E4, 0);
        // Same index, other tag, then back.
        fetch(32'h2000_0010, LINE_WORDS);
        fetch(32'h2000_0014, 0);
        fetch(32'h1000_0008, LINE_WORDS);
        fetch(32'h1000_0048, 0);
        // Misaligned.
        fetch(32'h1000_0001, 0);
        fetch(32'h1000_0042, 0);
        fetch(32'h3000_0003, 0);
        // Invalidate drops every line.
        pulse_invalidate();
        fetch(32'h1000_0048, LINE_WORDS);
        fetch(32'h1000_004C, 0);
        fetch(32'h1000_0090, LINE_WORDS);

        // Random mix over four tags, so lines keep conflicting.
        for (int i = 0; i < 150; i++) begin
            addr = $random(seed) & 32'h0000_03FC;
            if (($random(seed) & 7) == 0) begin
                addr[1:0] = 2'd1 + 2'(($random(seed) & 32'h7FFF_FFFF) % 3);
            end
            if (($random(seed) & 15) == 0) begin
                pulse_invalidate();
            end
            fetch(addr, predict_xfers(addr));
        end

        repeat (4) @(posedge clk);
        if (apb_req.psel !== 1'b0) begin
            $display("The APB bus stayed selected after the last response.");
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule
